// File: design/card_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cft_params.svh"

module card_alu
   import cft_pkg::*;
(
   input  logic            clk1,
   input  logic            arst_n,
   cft_cport_if.alu        cport
);

   logic [`CFT_WORD_W-1:0]   a;                     // Accumulator side
   logic [`CFT_WORD_W-1:0]   b;                     // Operand side
   logic [`CFT_WORD_W:0]     sum;                   // Extra bit for carry
   logic [`CFT_WORD_W-1:0]   res;
   logic                     res_l;
   logic                     res_v;

   assign a   = cport.ac;
   assign b   = cport.operand;
   assign sum = {1'b0, a} + {1'b0, b};

   ////////////////////////////////////////////////////////////
   //
   // Function select
   //
   ////////////////////////////////////////////////////////////

   always_comb begin
      res   = a;                                    // Pass-through by default
      res_l = 1'b0;
      res_v = 1'b0;
      case (cport.op)
         OP_LOAD: res = b;
         OP_ADD: begin
            res   = sum[`CFT_WORD_W-1:0];
            res_l = sum[`CFT_WORD_W];               // Carry out
            // Same-sign inputs, different-sign result
            res_v = (a[`CFT_WORD_W-1] == b[`CFT_WORD_W-1]) &&
                    (sum[`CFT_WORD_W-1] != a[`CFT_WORD_W-1]);
         end
         OP_AND:  res = a & b;
         OP_OR:   res = a | b;
         OP_XOR:  res = a ^ b;
         OP_NOT:  res = ~a;
         OP_ROL: begin
            res   = {a[`CFT_WORD_W-2:0], a[`CFT_WORD_W-1]};
            res_l = a[`CFT_WORD_W-1];               // MSB rotates into L too
         end
         default: ;                                 // NOP, JMP, skips, undefined
      endcase
   end

   ////////////////////////////////////////////////////////////
   //
   // Result register
   //
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk1 or negedge arst_n) begin
      if (!arst_n) begin
         cport.alu_out <= '0;
         cport.alu_fl  <= 1'b0;
         cport.alu_fv  <= 1'b0;
      end else if (cport.alu_go) begin
         cport.alu_out <= res;                      // Held for the write step
         cport.alu_fl  <= res_l;
         cport.alu_fv  <= res_v;
      end
   end

endmodule : card_alu

`default_nettype wire

// File: design/card_ctl.sv
`timescale 1ns/1ps
`default_nettype none

`include "cft_params.svh"

module card_ctl
   import cft_pkg::*;
(
   input  logic                     clk1,
   input  logic                     arst_n,
   input  logic                     instr_stb,      // One-cycle instruction strobe
   input  cft_op_t                  instr_op,
   input  logic [`CFT_WORD_W-1:0]   instr_operand,
   cft_cport_if.ctl                 cport,
   output logic                     fl,             // Carry (link) flag
   output logic                     fv,             // Overflow flag
   output logic                     busy,
   output logic                     done
);

   cft_state_t               state;
   cft_state_t               state_nx;
   cft_op_t                  op_q;                  // Instruction register
   logic [`CFT_WORD_W-1:0]   operand_q;
   logic                     take;                  // Strobe accepted this cycle
   logic                     in_write;

   ////////////////////////////////////////////////////////////
   //
   // Sequencer
   //
   ////////////////////////////////////////////////////////////

   assign take     = (state == ST_IDLE) && instr_stb;   // Strobes while busy are dropped
   assign in_write = (state == ST_WRITE);

   always_comb begin
      case (state)
         ST_IDLE:  state_nx = take ? ST_EXEC : ST_IDLE;
         ST_EXEC:  state_nx = ST_WRITE;
         ST_WRITE: state_nx = ST_IDLE;
         default:  state_nx = ST_IDLE;                   // Unused encoding
      endcase
   end

   always_ff @(posedge clk1 or negedge arst_n) begin
      if (!arst_n) begin
         state <= ST_IDLE;
         done  <= 1'b0;
      end else begin
         state <= state_nx;
         done  <= in_write;                              // Pulses after the write edge
      end
   end

   // Instruction latch
   always_ff @(posedge clk1) begin
      if (take) begin
         op_q      <= instr_op;
         operand_q <= instr_operand;
      end
   end

   assign busy = (state != ST_IDLE);                     // Falls with the write edge

   ////////////////////////////////////////////////////////////
   //
   // Card control
   //
   ////////////////////////////////////////////////////////////

   assign cport.op      = op_q;
   assign cport.operand = operand_q;
   assign cport.alu_go  = (state == ST_EXEC);            // ALU captures at end of EXEC
   assign cport.pc_we   = in_write;                      // Every instruction moves PC

   always_comb begin
      case (op_q)
         OP_LOAD, OP_ADD, OP_AND, OP_OR,
         OP_XOR, OP_NOT, OP_ROL: cport.ac_we = in_write;  // Data-modifying opcodes
         default:                cport.ac_we = 1'b0;
      endcase
   end

   // Skip tests look at AC before this instruction
   always_comb begin
      case (op_q)
         OP_JMP:  cport.pc_mode = PC_LOAD;
         OP_SZA:  cport.pc_mode = cport.fz ? PC_SKIP : PC_INC;
         OP_SNA:  cport.pc_mode = cport.fn ? PC_SKIP : PC_INC;
         default: cport.pc_mode = PC_INC;
      endcase
   end

   ////////////////////////////////////////////////////////////
   //
   // L and V flag register
   //
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk1 or negedge arst_n) begin
      if (!arst_n) begin
         fl <= 1'b0;
         fv <= 1'b0;
      end else if (in_write) begin
         if (op_q == OP_ADD) begin
            fl <= cport.alu_fl;                          // Carry out
            fv <= cport.alu_fv;                          // Signed overflow
         end else if (op_q == OP_ROL) begin
            fl <= cport.alu_fl;                          // Old MSB, V untouched
         end
      end
   end

endmodule : card_ctl

`default_nettype wire

// File: design/card_reg.sv
`timescale 1ns/1ps
`default_nettype none

`include "cft_params.svh"

module card_reg
   import cft_pkg::*;
(
   input  logic                     clk1,
   input  logic                     arst_n,
   cft_cport_if.regs                cport,
   output logic [`CFT_WORD_W-1:0]   pc              // Program counter
);

   logic [`CFT_WORD_W-1:0]   ac_q;                  // Accumulator
   logic [`CFT_WORD_W-1:0]   pc_nx;

   ////////////////////////////////////////////////////////////
   //
   // Accumulator
   //
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk1 or negedge arst_n) begin
      if (!arst_n) begin
         ac_q <= '0;
      end else if (cport.ac_we) begin
         ac_q <= cport.alu_out;                      // Write-back from ALU
      end
   end

   assign cport.ac = ac_q;
   assign cport.fz = (ac_q == '0);                   // Zero flag
   assign cport.fn = ac_q[`CFT_WORD_W-1];            // Negative flag

   ////////////////////////////////////////////////////////////
   //
   // Program counter
   //
   ////////////////////////////////////////////////////////////

   // Wraps modulo 2^16
   always_comb begin
      case (cport.pc_mode)
         PC_INC:  pc_nx = pc + `CFT_WORD_W'(1);
         PC_SKIP: pc_nx = pc + `CFT_WORD_W'(2);
         PC_LOAD: pc_nx = cport.operand;              // Jump target
         default: pc_nx = pc;                         // Unused mode holds
      endcase
   end

   always_ff @(posedge clk1 or negedge arst_n) begin
      if (!arst_n) begin
         pc <= `CFT_PC_RESET;
      end else if (cport.pc_we) begin
         pc <= pc_nx;
      end
   end

endmodule : card_reg

`default_nettype wire

// File: design/cft_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "cft_params.svh"

module cft_core
   import cft_pkg::*;
(
   input  logic                     clk1,
   input  logic                     arst_n,
   input  logic                     instr_stb,      // Instruction strobe
   input  logic [`CFT_OP_W-1:0]     instr_op,       // Opcode
   input  logic [`CFT_WORD_W-1:0]   instr_operand,
   output logic [`CFT_WORD_W-1:0]   ac,             // Accumulator
   output logic [`CFT_WORD_W-1:0]   pc,             // Program counter
   output logic                     fl,             // Link (carry)
   output logic                     fv,             // Overflow
   output logic                     fz,             // Zero
   output logic                     fn,             // Negative
   output logic                     busy,
   output logic                     done
);

   cft_cport_if cport ();                           // Local card connector

   ////////////////////////////////////////////////////////////
   //
   // Cards
   //
   ////////////////////////////////////////////////////////////

   card_ctl card_ctl (
      .clk1          (clk1),
      .arst_n        (arst_n),
      .instr_stb     (instr_stb),
      .instr_op      (cft_op_t'(instr_op)),          // Raw code onto the opcode type
      .instr_operand (instr_operand),
      .cport         (cport.ctl),
      .fl            (fl),
      .fv            (fv),
      .busy          (busy),
      .done          (done)
   );

   card_reg card_reg (
      .clk1          (clk1),
      .arst_n        (arst_n),
      .cport         (cport.regs),
      .pc            (pc)
   );

   card_alu card_alu (
      .clk1          (clk1),
      .arst_n        (arst_n),
      .cport         (cport.alu)
   );

   // REG card outputs brought off the connector
   assign ac = cport.ac;
   assign fz = cport.fz;
   assign fn = cport.fn;

endmodule : cft_core

`default_nettype wire

// File: design/cft_cport_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "cft_params.svh"

// Local card connector shared by the CTL, REG and ALU cards
interface cft_cport_if
   import cft_pkg::*;
();

   ////////////////////////////////////////////////////////////
   //
   // Driven by the CTL card
   //
   ////////////////////////////////////////////////////////////

   cft_op_t                  op;        // Latched opcode
   logic [`CFT_WORD_W-1:0]   operand;   // Latched operand
   logic                     alu_go;    // ALU capture strobe
   logic                     ac_we;     // Accumulator write
   logic                     pc_we;     // PC update
   cft_pc_mode_t             pc_mode;   // PC action for pc_we

   ////////////////////////////////////////////////////////////
   //
   // Driven by the REG card
   //
   ////////////////////////////////////////////////////////////

   logic [`CFT_WORD_W-1:0]   ac;        // Accumulator
   logic                     fz;        // AC is zero
   logic                     fn;        // AC sign bit

   ////////////////////////////////////////////////////////////
   //
   // Driven by the ALU card
   //
   ////////////////////////////////////////////////////////////

   logic [`CFT_WORD_W-1:0]   alu_out;   // Candidate result
   logic                     alu_fl;    // Candidate carry
   logic                     alu_fv;    // Candidate overflow

   modport ctl (
      output op, operand, alu_go, ac_we, pc_we, pc_mode,
      input  fz, fn, alu_fl, alu_fv
   );

   // Register card side
   modport regs (
      input  operand, ac_we, pc_we, pc_mode, alu_out,
      output ac, fz, fn
   );

   modport alu (
      input  op, operand, alu_go, ac,
      output alu_out, alu_fl, alu_fv
   );

endinterface : cft_cport_if

`default_nettype wire

// File: design/cft_params.svh
`ifndef CFT_PARAMS_SVH
`define CFT_PARAMS_SVH

////////////////////////////////////////////////////////////
//
// Architectural widths
//
////////////////////////////////////////////////////////////

// Data word, accumulator and program counter all share it
`define CFT_WORD_W 16

// Opcode field as it arrives on instr_op
`define CFT_OP_W 4

////////////////////////////////////////////////////////////
//
// Reset values
//
////////////////////////////////////////////////////////////

// Program counter after arst_n
`define CFT_PC_RESET `CFT_WORD_W'(0)

`endif // CFT_PARAMS_SVH

// File: design/cft_pkg.sv
`default_nettype none

`include "cft_params.svh"

package cft_pkg;

   ////////////////////////////////////////////////////////////
   //
   // Instruction opcodes
   //
   ////////////////////////////////////////////////////////////

   typedef enum logic [`CFT_OP_W-1:0] {
      OP_NOP  = 4'h0,               // No operation
      OP_LOAD = 4'h1,               // AC <- operand
      OP_ADD  = 4'h2,               // AC <- AC + operand, sets L and V
      OP_AND  = 4'h3,               // Bitwise and
      OP_OR   = 4'h4,               // Bitwise or
      OP_XOR  = 4'h5,               // Bitwise xor
      OP_NOT  = 4'h6,               // One's complement of AC
      OP_ROL  = 4'h7,               // Rotate left, L gets old MSB
      OP_JMP  = 4'h8,               // PC <- operand
      OP_SZA  = 4'h9,               // Skip if AC zero
      OP_SNA  = 4'hA                // Skip if AC negative
   } cft_op_t;                      // Codes B..F decode as NOP

   ////////////////////////////////////////////////////////////
   //
   // Sequencer and PC control
   //
   ////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,              // Waiting for a strobe
      ST_EXEC  = 2'd1,              // ALU registers its result
      ST_WRITE = 2'd2               // Write-back and PC update
   } cft_state_t;

   typedef enum logic [1:0] {
      PC_INC  = 2'd0,               // PC + 1
      PC_SKIP = 2'd1,               // PC + 2
      PC_LOAD = 2'd2                // PC <- operand
   } cft_pc_mode_t;

endpackage : cft_pkg

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_cft_core

status=0
./obj_dir/Vtb_cft_core > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "TEST FAILED" sim.log; then
   echo "Simulation failed, see sim.log"
   exit 1
fi

echo "Simulation finished without failures"

// File: src.f
+incdir+design
design/cft_pkg.sv
design/cft_cport_if.sv
design/card_ctl.sv
design/card_reg.sv
design/card_alu.sv
design/cft_core.sv
testbench/tb_clkgen.sv
testbench/cft_core_asserts.sv
testbench/tb_cft_core.sv

// File: testbench/cft_core_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module cft_core_asserts (
   input logic clk1,
   input logic arst_n,
   input logic busy,
   input logic done,
   input logic alu_go,                          // From the connector
   input logic pc_we
);

   // Sequencer stays quiet while held in reset
   a_reset_quiet: assert property (@(posedge clk1) !arst_n |-> (!busy && !done))
      else $error("busy or done high during reset");

   a_done_pulse: assert property (@(posedge clk1) disable iff (!arst_n) done |=> !done)
      else $error("done held for more than one cycle");

   // EXEC, then WRITE, then the done cycle
   a_go_to_done: assert property (@(posedge clk1) disable iff (!arst_n) alu_go |-> ##2 done)
      else $error("done missing two cycles after alu_go");

   // Write step is always followed by done
   a_we_done: assert property (@(posedge clk1) disable iff (!arst_n) pc_we |=> done)
      else $error("done missing after pc_we");

   a_done_we: assert property (@(posedge clk1) disable iff (!arst_n) done |-> $past(pc_we))
      else $error("done without a preceding pc_we");

endmodule : cft_core_asserts

bind card_ctl cft_core_asserts u_ctl_asserts (
   .clk1   (clk1),
   .arst_n (arst_n),
   .busy   (busy),
   .done   (done),
   .alu_go (cport.alu_go),
   .pc_we  (cport.pc_we)
);

`default_nettype wire

// File: testbench/tb_cft_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "cft_params.svh"

module tb_cft_core
   import cft_pkg::*;
();

   localparam int N_DIRECTED = 40;                      // Upper bound, directed part
   localparam int N_RAND     = 200;
   localparam int RESET_CYC  = 10;
   localparam int LIMIT      = 3 * (N_DIRECTED + N_RAND) + RESET_CYC + 100;

   typedef struct packed {
      logic [`CFT_WORD_W-1:0] ac;
      logic [`CFT_WORD_W-1:0] pc;
      logic                   fl;
      logic                   fv;
      logic                   fz;
      logic                   fn;
   } model_t;

   logic                     clk1;
   logic                     arst_n;
   logic                     instr_stb;
   logic [`CFT_OP_W-1:0]     instr_op;
   logic [`CFT_WORD_W-1:0]   instr_operand;
   logic [`CFT_WORD_W-1:0]   ac;
   logic [`CFT_WORD_W-1:0]   pc;
   logic                     fl;
   logic                     fv;
   logic                     fz;
   logic                     fn;
   logic                     busy;
   logic                     done;

   model_t   m;                                         // Architectural state of the model
   model_t   exp_q[$];                                  // Expected results in flight
   int       iss_q[$];                                  // Cycle of each accepted strobe
   int       cyc    = 0;
   int       errors = 0;
   integer   seed   = 45711;

   tb_clkgen u_clkgen (.clk1(clk1));

   cft_core u_cft_core (
      .clk1          (clk1),
      .arst_n        (arst_n),
      .instr_stb     (instr_stb),
      .instr_op      (instr_op),
      .instr_operand (instr_operand),
      .ac            (ac),
      .pc            (pc),
      .fl            (fl),
      .fv            (fv),
      .fz            (fz),
      .fn            (fn),
      .busy          (busy),
      .done          (done)
   );

   ////////////////////////////////////////////////////////////
   //
   // Reference model
   //
   ////////////////////////////////////////////////////////////

   function automatic model_t cft_ref_step(input model_t cur, input logic [`CFT_OP_W-1:0] op,
                                           input logic [`CFT_WORD_W-1:0] opd);
      model_t                 nx;
      logic [`CFT_WORD_W:0]   wide;
      int                     s_sum;
      nx    = cur;
      nx.pc = cur.pc + `CFT_WORD_W'(1);                 // Default advance, wraps
      case (op)
         OP_LOAD: nx.ac = opd;
         OP_ADD: begin
            wide  = {1'b0, cur.ac} + {1'b0, opd};
            s_sum = int'($signed(cur.ac)) + int'($signed(opd));
            nx.ac = wide[`CFT_WORD_W-1:0];
            nx.fl = wide[`CFT_WORD_W];                  // Unsigned carry
            nx.fv = (s_sum > 32767) || (s_sum < -32768); // Out of 16-bit signed range
         end
         OP_AND:  nx.ac = cur.ac & opd;
         OP_OR:   nx.ac = cur.ac | opd;
         OP_XOR:  nx.ac = cur.ac ^ opd;
         OP_NOT:  nx.ac = ~cur.ac;
         OP_ROL: begin
            nx.ac = {cur.ac[`CFT_WORD_W-2:0], cur.ac[`CFT_WORD_W-1]};
            nx.fl = cur.ac[`CFT_WORD_W-1];
         end
         OP_JMP:  nx.pc = opd;
         OP_SZA:  if (cur.ac == '0) nx.pc = cur.pc + `CFT_WORD_W'(2);
         OP_SNA:  if (cur.ac[`CFT_WORD_W-1]) nx.pc = cur.pc + `CFT_WORD_W'(2);
         default: ;                                     // NOP and undefined codes
      endcase
      nx.fz = (nx.ac == '0);
      nx.fn = nx.ac[`CFT_WORD_W-1];
      return nx;
   endfunction

   function automatic logic [`CFT_WORD_W-1:0] rand_word();
      logic [31:0] r;
      r = $random(seed);
      return r[`CFT_WORD_W-1:0];
   endfunction

   ////////////////////////////////////////////////////////////
   //
   // Checks
   //
   ////////////////////////////////////////////////////////////

   task automatic check_word(input string name, input logic [`CFT_WORD_W-1:0] exp_v,
                             input logic [`CFT_WORD_W-1:0] act_v);
      assert (act_v === exp_v) else begin
         $display("** Error %s: expected %h, got %h", name, exp_v, act_v);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic exp_v, input logic act_v);
      assert (act_v === exp_v) else begin
         $display("** Error %s: expected %h, got %h", name, exp_v, act_v);
         errors++;
      end
   endtask

   task automatic check_done();
      model_t e;
      int     t;
      assert (exp_q.size() != 0) else begin
         $display("Error: done pulsed with no instruction outstanding");
         errors++;
      end
      if (exp_q.size() != 0) begin
         e = exp_q.pop_front();
         t = iss_q.pop_front();
         check_word("ac", e.ac, ac);
         check_word("pc", e.pc, pc);
         check_bit("fl", e.fl, fl);
         check_bit("fv", e.fv, fv);
         check_bit("fz", e.fz, fz);
         check_bit("fn", e.fn, fn);
         check_bit("busy", 1'b0, busy);                 // Falls as done rises
         assert ((cyc - t) == 3) else begin             // Strobe edge to done
            $display("** Error latency: expected %h, got %h", 3, cyc - t);
            errors++;
         end
      end
   endtask

   always @(negedge clk1) begin
      if (arst_n && done) check_done();
   end

   always @(posedge clk1) begin
      cyc <= cyc + 1;
      if (cyc >= LIMIT) begin
         $display("Timeout: run did not finish within %0d cycles", LIMIT);
         $display("TEST FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   //
   // Stimulus
   //
   ////////////////////////////////////////////////////////////

   // Poke holds the strobe one more cycle with another instruction, landing in EXEC
   task automatic issue(input logic [`CFT_OP_W-1:0] op, input logic [`CFT_WORD_W-1:0] opd,
                        input bit poke);
      @(negedge clk1);
      while (busy) @(negedge clk1);
      instr_stb     = 1'b1;
      instr_op      = op;
      instr_operand = opd;
      m = cft_ref_step(m, op, opd);
      exp_q.push_back(m);
      iss_q.push_back(cyc);
      @(negedge clk1);
      check_bit("busy", 1'b1, busy);                    // Raised by the sampled strobe
      if (poke) begin
         instr_op      = OP_JMP;                        // Must be dropped
         instr_operand = ~opd;
         @(negedge clk1);
      end
      instr_stb = 1'b0;
   endtask

   initial begin
      logic [31:0] r_op;
      int          i;
      arst_n        = 1'b0;
      instr_stb     = 1'b0;
      instr_op      = '0;
      instr_operand = '0;
      m             = '{ac: '0, pc: `CFT_PC_RESET, fl: 1'b0, fv: 1'b0, fz: 1'b1, fn: 1'b0};
      repeat (RESET_CYC) @(negedge clk1);
      arst_n = 1'b1;
      @(negedge clk1);
      check_word("ac", '0, ac);                         // Reset state
      check_word("pc", `CFT_PC_RESET, pc);
      check_bit("fl", 1'b0, fl);
      check_bit("fv", 1'b0, fv);
      check_bit("fz", 1'b1, fz);
      check_bit("fn", 1'b0, fn);
      check_bit("busy", 1'b0, busy);
      check_bit("done", 1'b0, done);
      for (i = 0; i < 2; i++) begin                     // Logic ops
         issue(OP_LOAD, rand_word(), 1'b0);
         issue(OP_AND, rand_word(), 1'b0);
         issue(OP_OR, rand_word(), 1'b0);
         issue(OP_XOR, rand_word(), 1'b0);
         issue(OP_NOT, rand_word(), 1'b0);
      end
      issue(OP_LOAD, 16'h7FFF, 1'b0);                   // Signed overflow
      issue(OP_ADD, 16'h0001, 1'b0);
      issue(OP_LOAD, 16'hFFFF, 1'b0);                   // Carry to zero
      issue(OP_ADD, 16'h0001, 1'b0);
      issue(OP_ADD, rand_word(), 1'b0);
      issue(OP_ADD, rand_word(), 1'b0);
      issue(OP_LOAD, 16'h8000, 1'b0);                   // Carry and overflow
      issue(OP_ADD, 16'h8000, 1'b0);
      issue(OP_LOAD, 16'h4001, 1'b0);                   // Two ROLs drop then raise L
      issue(OP_ROL, '0, 1'b0);
      issue(OP_ROL, '0, 1'b0);
      issue(OP_AND, rand_word(), 1'b0);                 // L, V must hold
      issue(OP_XOR, rand_word(), 1'b0);
      issue(OP_LOAD, 16'h0000, 1'b0);                   // PC control
      issue(OP_JMP, 16'hFFFF, 1'b0);
      issue(OP_SZA, '0, 1'b0);                          // Skip wraps FFFF to 0001
      issue(OP_SNA, '0, 1'b0);
      issue(OP_LOAD, 16'h8000, 1'b0);
      issue(OP_JMP, 16'hFFFE, 1'b0);
      issue(OP_SNA, '0, 1'b0);
      issue(OP_SZA, '0, 1'b0);
      issue(OP_JMP, rand_word(), 1'b0);
      issue(OP_LOAD, rand_word(), 1'b1);                // Strobe while busy
      issue(OP_ADD, rand_word(), 1'b1);
      for (i = 0; i < N_RAND; i++) begin
         r_op = $random(seed);
         issue(r_op[`CFT_OP_W-1:0], rand_word(), 1'b0);
      end
      while (exp_q.size() != 0) @(negedge clk1);
      @(negedge clk1);
      $display("Errors: %0d", errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule : tb_cft_core

`default_nettype wire

// File: testbench/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
   output logic clk1                            // Single-phase core clock
);

   initial begin
      clk1 = 1'b0;
   end

   always #10 clk1 = ~clk1;                     // 20 ns period

endmodule : tb_clkgen

`default_nettype wire
